// File: cam_pkg.sv
package cam_pkg;

    // full sensor frame
    localparam int frame_cols = 640;  // also the row stride
    localparam int frame_rows = 480;

    localparam int col_w = $clog2(frame_cols + 1);  // holds the clamp value
    localparam int row_w = $clog2(frame_rows + 1);

    // frame buffer side
    localparam int addr_w = 19;
    localparam int pix_w  = 24;  // rgb888

    // writer fifo depth, same as the credit pool
    localparam int credits    = 4;
    localparam int cred_w     = $clog2(credits + 1);
    localparam int fifo_ptr_w = $clog2(credits);

    typedef enum logic [1:0] {
        ctrl_reset,
        ctrl_init,
        ctrl_stream,
        ctrl_hold  // host owns the buffer
    } ctrl_state_t;

endpackage

// File: sccb_pkg.sv
package sccb_pkg;

    localparam logic [7:0] sccb_id = 8'h42;  // ov7670 write address

    // quarter bit period in system clocks
    localparam int sccb_div   = 4;
    localparam int sccb_div_w = $clog2(sccb_div);

    localparam int reg_count = 6;
    localparam int reg_idx_w = $clog2(reg_count);

    // {register, value}
    localparam logic [15:0] reg_table [reg_count] = '{
        16'h1280,  // com7 soft reset
        16'h1101,  // clkrc prescale
        16'h1204,  // com7 rgb output
        16'h8c02,  // rgb444 enable, xr gb word order
        16'h40d0,  // com15 full range
        16'h3a04   // tslb byte order
    };

    typedef enum logic [2:0] {
        sccb_idle,
        sccb_start,
        sccb_bit,
        sccb_ack,   // don't care bit, line released
        sccb_stop,
        sccb_done
    } sccb_state_t;

endpackage

// File: cam_sccb_init.sv
`timescale 1ns/1ps

module cam_sccb_init (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic init_start,
    output logic sioc,
    output logic siod_out,
    output logic siod_oe,
    output logic init_done
);
    import sccb_pkg::*;

    sccb_state_t           state;
    logic [sccb_div_w-1:0] div_cnt;
    logic [1:0]            quarter;   // position inside one bit
    logic [2:0]            bit_idx;
    logic [1:0]            byte_idx;  // id, register, value
    logic [reg_idx_w-1:0]  entry;
    logic [7:0]            tx_byte;
    logic                  tick;

    assign tick = (div_cnt == sccb_div_w'(sccb_div - 1));

    always_comb begin
        case (byte_idx)
            2'd0:    tx_byte = sccb_id;
            2'd1:    tx_byte = reg_table[entry][15:8];
            default: tx_byte = reg_table[entry][7:0];
        endcase
    end

    // bus levels follow state and quarter
    always_comb begin
        sioc     = 1'b1;
        siod_out = 1'b1;
        siod_oe  = 1'b0;
        case (state)
            sccb_start: begin
                siod_oe  = 1'b1;
                siod_out = (quarter == 2'd0);  // falls while sioc high
                sioc     = (quarter != 2'd3);
            end
            sccb_bit: begin
                siod_oe  = 1'b1;
                siod_out = tx_byte[bit_idx];
                sioc     = (quarter == 2'd1) || (quarter == 2'd2);
            end
            sccb_ack: begin
                sioc = (quarter == 2'd1) || (quarter == 2'd2);
            end
            sccb_stop: begin
                siod_oe  = (quarter != 2'd3);
                siod_out = quarter[1];  // rises while sioc high
                sioc     = (quarter != 2'd0);
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= sccb_idle;
            div_cnt   <= '0;
            quarter   <= '0;
            bit_idx   <= '0;
            byte_idx  <= '0;
            entry     <= '0;
            init_done <= 1'b0;
        end else begin
            case (state)
                sccb_idle: begin
                    if (init_start) begin
                        state <= sccb_start;
                        entry <= '0;
                    end
                end
                sccb_done: ;
                default: begin
                    div_cnt <= tick ? '0 : div_cnt + 1'b1;
                    if (tick) begin
                        quarter <= quarter + 2'd1;
                        if (quarter == 2'd3) begin
                            case (state)
                                sccb_start: begin
                                    state    <= sccb_bit;
                                    byte_idx <= 2'd0;
                                    bit_idx  <= 3'd7;
                                end
                                sccb_bit: begin
                                    if (bit_idx == 3'd0) state <= sccb_ack;
                                    else bit_idx <= bit_idx - 3'd1;
                                end
                                sccb_ack: begin
                                    if (byte_idx == 2'd2) begin
                                        state <= sccb_stop;
                                    end else begin
                                        byte_idx <= byte_idx + 2'd1;
                                        bit_idx  <= 3'd7;
                                        state    <= sccb_bit;
                                    end
                                end
                                sccb_stop: begin
                                    if (entry == reg_idx_w'(reg_count - 1)) begin
                                        state     <= sccb_done;
                                        init_done <= 1'b1;
                                    end else begin
                                        entry <= entry + 1'b1;
                                        state <= sccb_start;
                                    end
                                end
                                default: ;
                            endcase
                        end
                    end
                end
            endcase
        end
    end

endmodule

// File: cam_pixel_capture.sv
`timescale 1ns/1ps

module cam_pixel_capture (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       pclk,
    input  logic                       vsync,
    input  logic                       href,
    input  logic [7:0]                 data,
    input  logic                       capture_arm,
    input  logic                       credit_ret,
    output logic                       pix_valid,
    output logic [cam_pkg::addr_w-1:0] pix_addr,
    output logic [cam_pkg::pix_w-1:0]  pix_data,
    output logic                       frame_end,
    output logic                       overflow
);
    import cam_pkg::*;

    logic [2:0]        pclk_sync, vsync_sync, href_sync;  // [1] synced, [2] previous
    logic [7:0]        data_s1, data_s2;
    logic              pclk_rise, vsync_rise, vsync_fall, href_rise, href_fall;
    logic              sample;
    logic              active;  // armed frame in progress
    logic              phase;   // 0 red byte, 1 green/blue byte
    logic [3:0]        red;
    logic [col_w-1:0]  col, s1_col;
    logic [row_w-1:0]  row, s1_row;
    logic              s1_valid, s2_valid;
    logic [pix_w-1:0]  s1_data, s2_data;
    logic [addr_w-1:0] s2_addr;
    logic [1:0]        end_pipe;  // matches the pixel pipeline depth
    logic [cred_w-1:0] credit_cnt;
    logic              spend;

    assign pclk_rise  = pclk_sync[1] & ~pclk_sync[2];
    assign vsync_rise = vsync_sync[1] & ~vsync_sync[2];
    assign vsync_fall = ~vsync_sync[1] & vsync_sync[2];
    assign href_rise  = href_sync[1] & ~href_sync[2];
    assign href_fall  = ~href_sync[1] & href_sync[2];
    assign sample     = pclk_rise && href_sync[1] && active && !href_rise;
    assign spend      = s2_valid && (credit_cnt != '0);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pclk_sync  <= '0;
            vsync_sync <= '0;
            href_sync  <= '0;
            active     <= 1'b0;
            phase      <= 1'b0;
            col        <= '0;
            row        <= '0;
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            pix_valid  <= 1'b0;
            end_pipe   <= '0;
            frame_end  <= 1'b0;
            credit_cnt <= cred_w'(credits);
            overflow   <= 1'b0;
        end else begin
            pclk_sync  <= {pclk_sync[1:0], pclk};
            vsync_sync <= {vsync_sync[1:0], vsync};
            href_sync  <= {href_sync[1:0], href};
            if (vsync_fall) begin
                active <= capture_arm;
                row    <= '0;
            end else if (vsync_rise) begin
                active <= 1'b0;
            end
            s1_valid <= 1'b0;
            if (href_rise) begin
                col   <= '0;
                phase <= 1'b0;
            end else if (href_fall) begin
                if (active && row < row_w'(frame_rows)) row <= row + 1'b1;
            end else if (sample) begin
                phase <= ~phase;
                if (phase) begin
                    s1_valid <= (col < col_w'(frame_cols)) && (row < row_w'(frame_rows));
                    if (col < col_w'(frame_cols)) col <= col + 1'b1;
                end
            end
            s2_valid   <= s1_valid;
            pix_valid  <= spend;
            credit_cnt <= credit_cnt + cred_w'(credit_ret) - cred_w'(spend);
            if (s2_valid && credit_cnt == '0) overflow <= 1'b1;  // sticky
            end_pipe  <= {end_pipe[0], vsync_rise && active};
            frame_end <= end_pipe[1];
        end
    end

    always_ff @(posedge i_clk) begin
        data_s1 <= data;
        data_s2 <= data_s1;
        if (sample && !phase) red <= data_s2[3:0];
        if (sample && phase) begin
            s1_col  <= col;
            s1_row  <= row;
            s1_data <= {red, red, data_s2[7:4], data_s2[7:4], data_s2[3:0], data_s2[3:0]};
        end
        s2_addr <= addr_w'(s1_row) * addr_w'(frame_cols) + addr_w'(s1_col);
        s2_data <= s1_data;
        if (spend) begin
            pix_addr <= s2_addr;
            pix_data <= s2_data;
        end
    end

endmodule

// File: cam_frame_ctrl.sv
`timescale 1ns/1ps

module cam_frame_ctrl (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic init_done,
    input  logic frame_end,
    input  logic capture,
    input  logic nios_finish,
    output logic init_start,
    output logic capture_arm,
    output logic frame_held
);
    import cam_pkg::*;

    ctrl_state_t state;
    logic        pending;  // host asked, current frame still running

    assign capture_arm = (state == ctrl_stream);
    assign frame_held  = (state == ctrl_hold);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= ctrl_reset;
            init_start <= 1'b0;
            pending    <= 1'b0;
        end else begin
            init_start <= 1'b0;
            case (state)
                ctrl_reset: begin
                    state      <= ctrl_init;
                    init_start <= 1'b1;
                end
                ctrl_init: begin
                    if (init_done) state <= ctrl_stream;
                end
                ctrl_stream: begin
                    if (frame_end && (pending || capture)) begin
                        state   <= ctrl_hold;  // frame finished, keep buffer
                        pending <= 1'b0;
                    end else if (capture) begin
                        pending <= 1'b1;
                    end
                end
                ctrl_hold: begin
                    if (nios_finish) state <= ctrl_stream;
                end
                default: state <= ctrl_reset;
            endcase
        end
    end

endmodule

// File: cam_mem_writer.sv
`timescale 1ns/1ps

module cam_mem_writer (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       pix_valid,
    input  logic [cam_pkg::addr_w-1:0] pix_addr,
    input  logic [cam_pkg::pix_w-1:0]  pix_data,
    input  logic                       mem_ready,
    output logic                       credit_ret,
    output logic                       mem_we,
    output logic [cam_pkg::addr_w-1:0] mem_addr,
    output logic [cam_pkg::pix_w-1:0]  mem_data
);
    import cam_pkg::*;

    logic [addr_w-1:0]     addr_mem [credits];
    logic [pix_w-1:0]      data_mem [credits];
    logic [fifo_ptr_w-1:0] wr_ptr, rd_ptr;  // depth is a power of two, pointers just wrap
    logic [cred_w-1:0]     count;
    logic                  xfer;

    // head entry sits on the port until taken
    assign mem_we   = (count != '0);
    assign mem_addr = addr_mem[rd_ptr];
    assign mem_data = data_mem[rd_ptr];
    assign xfer     = mem_we && mem_ready;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
        end else begin
            if (pix_valid) wr_ptr <= wr_ptr + 1'b1;  // no full check, credits bound it
            if (xfer) rd_ptr <= rd_ptr + 1'b1;
            count      <= count + cred_w'(pix_valid) - cred_w'(xfer);
            credit_ret <= xfer;
        end
    end

    always_ff @(posedge i_clk) begin
        if (pix_valid) begin
            addr_mem[wr_ptr] <= pix_addr;
            data_mem[wr_ptr] <= pix_data;
        end
    end

endmodule

// File: cam_top.sv
`timescale 1ns/1ps

module cam_top (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       ov_pclk,
    input  logic                       ov_vsync,
    input  logic                       ov_href,
    input  logic [7:0]                 ov_data,
    input  logic                       capture,
    input  logic                       nios_finish,
    input  logic                       mem_ready,
    output logic                       ov_xclk,
    output logic                       ov_sioc,
    output logic                       ov_siod_out,
    output logic                       ov_siod_oe,
    output logic                       ov_pwdn,
    output logic                       ov_reset,
    output logic                       mem_we,
    output logic [cam_pkg::addr_w-1:0] mem_addr,
    output logic [cam_pkg::pix_w-1:0]  mem_data,
    output logic                       frame_held,
    output logic                       overflow
);
    import cam_pkg::*;

    logic              init_start, init_done;
    logic              capture_arm, frame_end;
    logic              pix_valid, credit_ret;
    logic [addr_w-1:0] pix_addr;
    logic [pix_w-1:0]  pix_data;

    assign ov_pwdn = 1'b0;  // sensor always powered

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ov_xclk  <= 1'b0;
            ov_reset <= 1'b0;  // held in reset until init begins
        end else begin
            ov_xclk <= ~ov_xclk;
            if (init_start) ov_reset <= 1'b1;
        end
    end

    cam_sccb_init u_sccb_init (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .init_start (init_start),
        .sioc       (ov_sioc),
        .siod_out   (ov_siod_out),
        .siod_oe    (ov_siod_oe),
        .init_done  (init_done)
    );

    cam_pixel_capture u_capture (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .pclk        (ov_pclk),
        .vsync       (ov_vsync),
        .href        (ov_href),
        .data        (ov_data),
        .capture_arm (capture_arm),
        .credit_ret  (credit_ret),
        .pix_valid   (pix_valid),
        .pix_addr    (pix_addr),
        .pix_data    (pix_data),
        .frame_end   (frame_end),
        .overflow    (overflow)
    );

    cam_frame_ctrl u_frame_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .init_done   (init_done),
        .frame_end   (frame_end),
        .capture     (capture),
        .nios_finish (nios_finish),
        .init_start  (init_start),
        .capture_arm (capture_arm),
        .frame_held  (frame_held)
    );

    cam_mem_writer u_mem_writer (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .pix_valid  (pix_valid),
        .pix_addr   (pix_addr),
        .pix_data   (pix_data),
        .mem_ready  (mem_ready),
        .credit_ret (credit_ret),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_data   (mem_data)
    );

endmodule

// File: tb_cam_sensor.sv
`timescale 1ns/1ps

module tb_cam_sensor (
    input  logic       i_clk,
    input  logic       go,
    input  logic [7:0] rows,
    input  logic [7:0] cols,
    input  logic [7:0] next_byte,
    output logic       pclk,
    output logic       vsync,
    output logic       href,
    output logic [7:0] data,
    output logic       byte_used,  // data just took next_byte
    output logic [7:0] pix_row,
    output logic [7:0] pix_col,
    output logic       busy
);

    // pclk period of four system clocks with data moving while pclk is low
    task automatic pclk_period(input logic hr, input logic take, input int r, input int c);
        @(negedge i_clk);
        pclk      <= 1'b0;
        href      <= hr;
        byte_used <= take;
        if (take) begin
            data    <= next_byte;
            pix_row <= 8'(r);
            pix_col <= 8'(c);
        end
        @(negedge i_clk);
        byte_used <= 1'b0;
        @(negedge i_clk);
        pclk <= 1'b1;
        @(negedge i_clk);
    endtask

    task automatic send_frame();
        vsync <= 1'b0;  // falling edge opens the frame
        repeat (2) pclk_period(1'b0, 1'b0, 0, 0);
        for (int r = 0; r < int'(rows); r++) begin
            for (int b = 0; b < 2 * int'(cols); b++) begin
                pclk_period(1'b1, 1'b1, r, b / 2);
            end
            repeat (3) pclk_period(1'b0, 1'b0, 0, 0);  // line blanking
        end
        vsync <= 1'b1;  // rising edge closes it
        repeat (3) pclk_period(1'b0, 1'b0, 0, 0);
    endtask

    initial begin
        pclk      <= 1'b0;
        vsync     <= 1'b1;
        href      <= 1'b0;
        data      <= 8'd0;
        byte_used <= 1'b0;
        pix_row   <= 8'd0;
        pix_col   <= 8'd0;
        busy      <= 1'b0;
        forever begin
            @(negedge i_clk);
            if (go) begin
                busy <= 1'b1;
                send_frame();
                busy <= 1'b0;
            end
        end
    end

endmodule

// File: tb_cam_top.sv
`timescale 1ns/1ps

module tb_cam_top;
    import cam_pkg::*;
    import sccb_pkg::*;

    localparam int t_rows         = 4;
    localparam int t_cols         = 12;
    localparam int n_frames       = 6;
    localparam int sccb_cycles    = reg_count * (2 + 3 * 9) * 4 * sccb_div;
    localparam int timeout_cycles = 2 * (sccb_cycles + n_frames * t_rows * t_cols * 8);

    logic              i_clk       = 1'b0;
    logic              i_rst_n     = 1'b0;
    logic              capture     = 1'b0;
    logic              nios_finish = 1'b0;
    logic              mem_ready   = 1'b0;
    logic              ov_pclk, ov_vsync, ov_href;
    logic [7:0]        ov_data;
    logic              ov_xclk, ov_sioc, ov_siod_out, ov_siod_oe, ov_pwdn, ov_reset;
    logic              mem_we, frame_held, overflow;
    logic [addr_w-1:0] mem_addr;
    logic [pix_w-1:0]  mem_data;

    // sensor model control
    logic       go        = 1'b0;
    logic [7:0] rows      = 8'd0;
    logic [7:0] cols      = 8'd0;
    logic [7:0] next_byte = 8'd0;
    logic       byte_used, busy;
    logic [7:0] sens_row, sens_col;

    logic [31:0]             lfsr = 32'hed43b1eb;
    logic [addr_w+pix_w-1:0] sb_q[$];
    logic [addr_w+pix_w-1:0] sb_head;
    logic [7:0]              first_byte;
    logic                    byte_phase = 1'b0;
    logic                    take_ready;
    logic [1:0]              ready_mode = 2'd0;  // 0 always, 1 random, 2 held low
    logic                    siod_line;
    logic [7:0]              sccb_shift;
    logic                    xclk_prev;
    int sccb_bits = 0, byte_no = 0, stop_count = 0;
    int px_total = 0, frame_first = 0, expect_px = 0, xfer_count = 0, cycle_count = 0;
    int checks = 0, errors = 0, tests = 0, failed = 0, test_err_start = 0;
    int x0, delay;

    always #4 i_clk = ~i_clk;

    cam_top u_cam_top (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .ov_pclk     (ov_pclk),
        .ov_vsync    (ov_vsync),
        .ov_href     (ov_href),
        .ov_data     (ov_data),
        .capture     (capture),
        .nios_finish (nios_finish),
        .mem_ready   (mem_ready),
        .ov_xclk     (ov_xclk),
        .ov_sioc     (ov_sioc),
        .ov_siod_out (ov_siod_out),
        .ov_siod_oe  (ov_siod_oe),
        .ov_pwdn     (ov_pwdn),
        .ov_reset    (ov_reset),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .frame_held  (frame_held),
        .overflow    (overflow)
    );

    tb_cam_sensor u_sensor (
        .i_clk     (i_clk),
        .go        (go),
        .rows      (rows),
        .cols      (cols),
        .next_byte (next_byte),
        .pclk      (ov_pclk),
        .vsync     (ov_vsync),
        .href      (ov_href),
        .data      (ov_data),
        .byte_used (byte_used),
        .pix_row   (sens_row),
        .pix_col   (sens_col),
        .busy      (busy)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // expected {address, rgb888} of one sensor pixel
    function automatic logic [addr_w+pix_w-1:0] expected_pixel(input int r, input int c,
                                                             input logic [7:0] b0,
                                                             input logic [7:0] b1);
        logic [addr_w-1:0] a;
        logic [pix_w-1:0]  d;
        a = addr_w'(r * frame_cols + c);
        d = {b0[3:0], b0[3:0], b1[7:4], b1[7:4], b1[3:0], b1[3:0]};
        return {a, d};
    endfunction

    function automatic logic [7:0] sccb_expected(input int n);
        case (n % 3)
            0:       return sccb_id;
            1:       return reg_table[n / 3][15:8];
            default: return reg_table[n / 3][7:0];
        endcase
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_err_start) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed++;
            $display("test %0d %s: %0d errors", tests, name, errors - test_err_start);
        end
        test_err_start = errors;
    endtask

    task automatic run_frame(input int n_rows, input int n_cols, input int n_expect);
        frame_first = px_total;
        expect_px   = n_expect;
        @(negedge i_clk);
        rows <= 8'(n_rows);
        cols <= 8'(n_cols);
        go   <= 1'b1;
        @(negedge i_clk);
        go <= 1'b0;
        @(negedge i_clk);
        while (busy) @(negedge i_clk);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (sb_q.size() != 0 && n < 200) begin
            @(negedge i_clk);
            n++;
        end
        repeat (4) @(negedge i_clk);
        checks++;
        assert (sb_q.size() == 0) else begin
            errors++;
            $display("%0d expected pixels were never written to memory", sb_q.size());
        end
    endtask

    // sensor bytes in, mem_ready out, transfers checked against the scoreboard
    always @(negedge i_clk) begin
        if (byte_used) begin
            if (!byte_phase) begin
                first_byte = ov_data;
            end else begin
                if (px_total - frame_first < expect_px)
                    sb_q.push_back(expected_pixel(int'(sens_row), int'(sens_col),
                                                  first_byte, ov_data));
                px_total++;
            end
            byte_phase = !byte_phase;
            next_byte <= 8'(rand_bits(8));
        end
        case (ready_mode)
            2'd0:    take_ready = 1'b1;
            2'd1:    take_ready = (rand_bits(2) != 0);  // 75 percent
            default: take_ready = 1'b0;
        endcase
        mem_ready <= take_ready;
        if (mem_we && take_ready) begin  // transfer on the coming rising edge
            xfer_count++;
            checks++;
            assert (sb_q.size() != 0) else begin
                errors++;
                $display("memory write at %0t with no pixel expected", $time);
            end
            if (sb_q.size() != 0) begin
                sb_head = sb_q.pop_front();
                check_eq("mem_addr", 32'(sb_head[pix_w +: addr_w]), 32'(mem_addr));
                check_eq("mem_data", 32'(sb_head[pix_w-1:0]), 32'(mem_data));
            end
        end
    end

    // sccb decoder sees a released line as high
    assign siod_line = ov_siod_oe ? ov_siod_out : 1'b1;

    always @(negedge siod_line) begin
        if (ov_sioc === 1'b1 && i_rst_n === 1'b1) sccb_bits = 0;  // start
    end

    always @(posedge siod_line) begin
        if (ov_sioc === 1'b1 && i_rst_n === 1'b1) stop_count++;
    end

    always @(posedge ov_sioc) begin
        if (i_rst_n === 1'b1) begin
            if (sccb_bits == 8) begin
                sccb_bits = 0;  // ack clock
            end else begin
                sccb_shift = {sccb_shift[6:0], siod_line};
                sccb_bits++;
                if (sccb_bits == 8) begin
                    checks++;
                    assert (byte_no < 3 * reg_count) else begin
                        errors++;
                        $display("extra sccb byte %0h at %0t", sccb_shift, $time);
                    end
                    if (byte_no < 3 * reg_count)
                        check_eq("siod byte", 32'(sccb_expected(byte_no)), 32'(sccb_shift));
                    byte_no++;
                end
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("run stopped by timeout after %0d cycles", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        next_byte <= 8'(rand_bits(8));
        @(negedge i_clk);
        check_eq("ov_sioc", 1, ov_sioc);
        check_eq("ov_siod_oe", 0, ov_siod_oe);
        check_eq("mem_we", 0, mem_we);
        check_eq("frame_held", 0, frame_held);
        check_eq("overflow", 0, overflow);
        check_eq("ov_reset", 0, ov_reset);
        check_eq("ov_pwdn", 0, ov_pwdn);
        repeat (2) @(negedge i_clk);
        i_rst_n = 1'b1;
        check_eq("xfer_count", 0, xfer_count);
        end_test("reset state");

        while (stop_count < reg_count) @(negedge i_clk);
        check_eq("byte_no", 3 * reg_count, byte_no);
        check_eq("xfer_count", 0, xfer_count);
        check_eq("ov_reset", 1, ov_reset);
        xclk_prev = ov_xclk;
        @(negedge i_clk);
        check_eq("ov_xclk", 32'(!xclk_prev), 32'(ov_xclk));  // half rate toggle
        repeat (2 * sccb_div + 4) @(negedge i_clk);  // stop tail and one controller step
        end_test("sccb init");

        x0 = xfer_count;
        run_frame(t_rows, t_cols, t_rows * t_cols);
        wait_drain();
        check_eq("xfer_count", t_rows * t_cols, xfer_count - x0);
        check_eq("overflow", 0, overflow);
        end_test("pixel path");

        ready_mode <= 2'd1;
        x0 = xfer_count;
        run_frame(t_rows, t_cols, t_rows * t_cols);
        wait_drain();
        ready_mode <= 2'd0;
        check_eq("xfer_count", t_rows * t_cols, xfer_count - x0);
        check_eq("overflow", 0, overflow);
        end_test("back-pressure");

        delay = 60 + int'(rand_bits(6));
        x0    = xfer_count;
        fork
            run_frame(t_rows, t_cols, t_rows * t_cols);
            begin
                repeat (delay) @(negedge i_clk);
                capture <= 1'b1;
            end
        join
        check_eq("frame_held", 1, frame_held);
        capture <= 1'b0;
        wait_drain();
        check_eq("xfer_count", t_rows * t_cols, xfer_count - x0);
        x0 = xfer_count;
        run_frame(t_rows, t_cols, 0);  // held buffer leaves the frame unarmed
        repeat (20) @(negedge i_clk);
        check_eq("xfer_count", 0, xfer_count - x0);
        check_eq("frame_held", 1, frame_held);
        nios_finish <= 1'b1;
        @(negedge i_clk);
        nios_finish <= 1'b0;
        check_eq("frame_held", 0, frame_held);
        x0 = xfer_count;
        run_frame(t_rows, t_cols, t_rows * t_cols);
        wait_drain();
        check_eq("xfer_count", t_rows * t_cols, xfer_count - x0);
        end_test("capture hold");

        ready_mode <= 2'd2;
        x0 = xfer_count;
        run_frame(1, t_cols, credits);
        check_eq("overflow", 1, overflow);
        check_eq("mem_we", 1, mem_we);  // head entry waits on the port
        ready_mode <= 2'd0;
        wait_drain();
        check_eq("xfer_count", credits, xfer_count - x0);
        repeat (10) @(negedge i_clk);
        check_eq("overflow", 1, overflow);  // sticky
        end_test("overflow");

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
cam_pkg.sv
sccb_pkg.sv
cam_sccb_init.sv
cam_pixel_capture.sv
cam_frame_ctrl.sv
cam_mem_writer.sv
cam_top.sv
tb_cam_sensor.sv
tb_cam_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_cam_top
FILELIST  := filelist.f
VFLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
